//--- ws2812_pkg.sv
package ws2812_pkg;

    // timing in sys_clk cycles, 50 MHz
    localparam int unsigned RESET_GAP_CYCLES = 5000;  // 100 us low before data
    localparam int unsigned BIT_CYCLES       = 68;    // 1.36 us slot
    localparam int unsigned T0H_CYCLES       = 17;    // 0.34 us high
    localparam int unsigned T1H_CYCLES       = 51;    // 1.02 us high

    // strip geometry
    localparam int unsigned BITS_PER_PIXEL   = 24;
    localparam int unsigned PIXELS_PER_STRIP = 20;
    localparam int unsigned FRAME_PIXELS     = 40;
    localparam int unsigned FRAME_BITS       = 960;

    // pixel as held in the input frame
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } pixel_rgb_t;

    // byte order on the wire
    typedef struct packed {
        logic [7:0] green;
        logic [7:0] red;
        logic [7:0] blue;
    } pixel_grb_t;

    typedef union packed {
        logic [23:0] bits;  // shifted out from bit 23
        pixel_grb_t  grb;
    } pixel_word_u;

    typedef struct packed {
        logic       active;     // data slots running
        logic [4:0] pixel_idx;  // 0..19
        logic [4:0] bit_idx;    // 0 goes out first
        logic [6:0] phase;      // 0..67
    } ws2812_slot_t;

endpackage

//--- ws2812_pixel_buffer.sv
`timescale 1ns/1ps

module ws2812_pixel_buffer (
    input  logic                                   sys_clk,
    input  logic                                   sys_rst_n,
    input  logic                                   frame_start,
    input  logic [ws2812_pkg::FRAME_BITS-1:0]      frame_data,
    input  ws2812_pkg::ws2812_slot_t               slot,
    output ws2812_pkg::pixel_word_u                pixel_a,
    output ws2812_pkg::pixel_word_u                pixel_b
);

    logic [ws2812_pkg::FRAME_BITS-1:0] frame_q;
    logic [5:0]                        idx_a;
    logic [5:0]                        idx_b;
    ws2812_pkg::pixel_rgb_t            rgb_a;
    ws2812_pkg::pixel_rgb_t            rgb_b;

    // frame is held until the next start
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            frame_q <= '0;
        end else if (frame_start) begin
            frame_q <= frame_data;
        end
    end

    // strip b walks the upper half backwards
    assign idx_a = {1'b0, slot.pixel_idx};
    assign idx_b = 6'(ws2812_pkg::FRAME_PIXELS - 1) - idx_a;

    assign rgb_a = ws2812_pkg::pixel_rgb_t'(
        frame_q[idx_a * ws2812_pkg::BITS_PER_PIXEL +: ws2812_pkg::BITS_PER_PIXEL]);
    assign rgb_b = ws2812_pkg::pixel_rgb_t'(
        frame_q[idx_b * ws2812_pkg::BITS_PER_PIXEL +: ws2812_pkg::BITS_PER_PIXEL]);

    // rgb in, grb out
    always_comb begin
        pixel_a.grb.green = rgb_a.green;
        pixel_a.grb.red   = rgb_a.red;
        pixel_a.grb.blue  = rgb_a.blue;
        pixel_b.grb.green = rgb_b.green;
        pixel_b.grb.red   = rgb_b.red;
        pixel_b.grb.blue  = rgb_b.blue;
    end

endmodule

//--- ws2812_sequencer.sv
`timescale 1ns/1ps

module ws2812_sequencer (
    input  logic                     sys_clk,
    input  logic                     sys_rst_n,
    input  logic                     frame_start,
    output ws2812_pkg::ws2812_slot_t slot,
    output logic                     busy,
    output logic                     frame_done
);

    logic [$clog2(ws2812_pkg::RESET_GAP_CYCLES)-1:0] gap_cnt;
    logic                                             gap_end;
    logic                                             last_phase;
    logic                                             last_bit;
    logic                                             last_pixel;

    assign gap_end    = 32'(gap_cnt) == ws2812_pkg::RESET_GAP_CYCLES - 1;
    assign last_phase = slot.phase == 7'(ws2812_pkg::BIT_CYCLES - 1);
    assign last_bit   = slot.bit_idx == 5'(ws2812_pkg::BITS_PER_PIXEL - 1);
    assign last_pixel = slot.pixel_idx == 5'(ws2812_pkg::PIXELS_PER_STRIP - 1);

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            slot       <= '0;
            gap_cnt    <= '0;
            busy       <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (frame_start) begin
                // new frame, also abandons one in flight
                slot    <= '0;
                gap_cnt <= '0;
                busy    <= 1'b1;
            end else if (busy && !slot.active) begin
                if (gap_end) begin
                    slot.active <= 1'b1;
                end else begin
                    gap_cnt <= gap_cnt + 1'b1;
                end
            end else if (slot.active) begin
                if (!last_phase) begin
                    slot.phase <= slot.phase + 1'b1;
                end else begin
                    slot.phase <= '0;
                    if (!last_bit) begin
                        slot.bit_idx <= slot.bit_idx + 1'b1;
                    end else begin
                        slot.bit_idx <= '0;
                        if (!last_pixel) begin
                            slot.pixel_idx <= slot.pixel_idx + 1'b1;
                        end else begin
                            // frame complete
                            slot.active    <= 1'b0;
                            slot.pixel_idx <= '0;
                            busy           <= 1'b0;
                            frame_done     <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    a_phase_range: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        slot.phase < 7'(ws2812_pkg::BIT_CYCLES)
    );

    a_pixel_range: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        slot.active |-> slot.pixel_idx < 5'(ws2812_pkg::PIXELS_PER_STRIP)
    );

    a_done_single: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        frame_done |=> !frame_done
    );

endmodule

//--- ws2812_bit_encoder.sv
`timescale 1ns/1ps

module ws2812_bit_encoder (
    input  logic                     sys_clk,
    input  logic                     sys_rst_n,
    input  ws2812_pkg::ws2812_slot_t slot,
    input  ws2812_pkg::pixel_word_u  pixel,
    output logic                     line
);

    logic [4:0] bit_pos;
    logic       bit_val;
    logic [6:0] high_time;

    // msb first
    assign bit_pos = 5'(ws2812_pkg::BITS_PER_PIXEL - 1) - slot.bit_idx;
    assign bit_val = pixel.bits[bit_pos];

    assign high_time = bit_val ? 7'(ws2812_pkg::T1H_CYCLES)
                               : 7'(ws2812_pkg::T0H_CYCLES);

    // high from the first cycle of the slot
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            line <= 1'b0;
        end else begin
            line <= slot.active && (slot.phase < high_time);
        end
    end

    // line must stay low through the reset gap and after the frame
    a_low_when_idle: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        !slot.active |=> !line
    );

endmodule

//--- ws2812_top.sv
`timescale 1ns/1ps

module ws2812_top (
    input  logic                              sys_clk,
    input  logic                              sys_rst_n,
    input  logic                              frame_start,
    input  logic [ws2812_pkg::FRAME_BITS-1:0] frame_data,
    output logic                              strip_a,
    output logic                              strip_b,
    output logic                              busy,
    output logic                              frame_done
);

    ws2812_pkg::ws2812_slot_t slot;
    ws2812_pkg::pixel_word_u  pixel_a;
    ws2812_pkg::pixel_word_u  pixel_b;

    ws2812_sequencer u_sequencer (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .frame_start(frame_start),
        .slot       (slot),
        .busy       (busy),
        .frame_done (frame_done)
    );

    ws2812_pixel_buffer u_pixel_buffer (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .frame_start(frame_start),
        .frame_data (frame_data),
        .slot       (slot),
        .pixel_a    (pixel_a),
        .pixel_b    (pixel_b)
    );

    // both strips share one slot timing
    ws2812_bit_encoder u_enc_a (
        .sys_clk  (sys_clk),
        .sys_rst_n(sys_rst_n),
        .slot     (slot),
        .pixel    (pixel_a),
        .line     (strip_a)
    );

    ws2812_bit_encoder u_enc_b (
        .sys_clk  (sys_clk),
        .sys_rst_n(sys_rst_n),
        .slot     (slot),
        .pixel    (pixel_b),
        .line     (strip_b)
    );

endmodule

//--- tb_ws2812.sv
`timescale 1ns/1ps

module tb_ws2812;

    // reset gap plus 480 bit slots per frame
    localparam int unsigned FRAME_CYCLES = ws2812_pkg::RESET_GAP_CYCLES
        + ws2812_pkg::PIXELS_PER_STRIP * ws2812_pkg::BITS_PER_PIXEL * ws2812_pkg::BIT_CYCLES;
    localparam int unsigned TIMEOUT_CYCLES = 4 * FRAME_CYCLES + 50_000;  // four frames plus margin

    logic                              sys_clk = 1'b0;
    logic                              sys_rst_n;
    logic                              frame_start;
    logic [ws2812_pkg::FRAME_BITS-1:0] frame_data;
    logic                              strip_a;
    logic                              strip_b;
    logic                              busy;
    logic                              frame_done;

    logic [ws2812_pkg::FRAME_BITS-1:0] sent_frame = '0;
    logic [1:0]  lines;
    logic        start_seen = 1'b0;
    int unsigned cycle_cnt = 0;
    int          check_count = 0;
    int          error_count = 0;
    int          done_count = 0;

    // decoder state per strip with strip a at index 0
    logic        prev_line [2] = '{1'b0, 1'b0};
    logic        got_first [2] = '{1'b0, 1'b0};
    logic        pulse_valid [2] = '{1'b0, 1'b0};
    int          hi_run [2] = '{0, 0};
    int          since_clear [2] = '{0, 0};
    int          since_rise [2] = '{0, 0};
    int          bit_cnt [2] = '{0, 0};
    int          word_cnt [2] = '{0, 0};
    logic [23:0] cur_word [2] = '{24'h0, 24'h0};
    logic [23:0] dec_words [2][20];

    ws2812_top i_dut (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .frame_start(frame_start),
        .frame_data (frame_data),
        .strip_a    (strip_a),
        .strip_b    (strip_b),
        .busy       (busy),
        .frame_done (frame_done)
    );

    assign lines = {strip_b, strip_a};

    initial begin
        forever #2 sys_clk = ~sys_clk;
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERR %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic note_failure(input string msg);
        error_count++;
        $display("failure at %0t: %s", $time, msg);
    endtask

    function automatic string strip_name(input int s);
        return (s == 0) ? "strip_a" : "strip_b";
    endfunction

    // strip a takes pixel p, strip b takes 39 - p, bytes go out as g, r, b
    function automatic logic [23:0] expected_word(input logic [ws2812_pkg::FRAME_BITS-1:0] frame,
                                                  input int strip, input int pixel);
        int          fp;
        logic [23:0] rgb;
        fp  = (strip == 0) ? pixel : 39 - pixel;
        rgb = frame[fp*24 +: 24];
        return {rgb[15:8], rgb[23:16], rgb[7:0]};
    endfunction

    function automatic logic [ws2812_pkg::FRAME_BITS-1:0] random_frame();
        logic [ws2812_pkg::FRAME_BITS-1:0] f;
        for (int i = 0; i < ws2812_pkg::FRAME_BITS / 32; i++) begin
            f[i*32 +: 32] = $urandom();
        end
        return f;
    endfunction

    always @(posedge sys_clk) begin
        start_seen <= frame_start;
        cycle_cnt  <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the DUT never finished its frame", cycle_cnt);
            $display("Test failures found");
            $finish;
        end
    end

    // decode both lines from run lengths
    always @(negedge sys_clk) begin
        for (int s = 0; s < 2; s++) begin
            if (start_seen) begin
                word_cnt[s]    = 0;
                bit_cnt[s]     = 0;
                since_clear[s] = 0;
                got_first[s]   = 1'b0;
                pulse_valid[s] = 1'b0;  // a pulse cut by the restart is dropped
            end else begin
                since_clear[s]++;
                since_rise[s]++;
                if (lines[s] && !prev_line[s]) begin
                    if (!got_first[s] && since_clear[s] < ws2812_pkg::RESET_GAP_CYCLES) begin
                        note_failure($sformatf("%s went high %0d cycles after start, inside the gap",
                                               strip_name(s), since_clear[s]));
                    end
                    if (got_first[s]) begin
                        check_val($sformatf("%s bit period", strip_name(s)),
                                  32'(since_rise[s]), 32'(ws2812_pkg::BIT_CYCLES));
                    end
                    got_first[s]   = 1'b1;
                    pulse_valid[s] = 1'b1;
                    hi_run[s]      = 1;
                    since_rise[s]  = 0;
                end else if (lines[s] && prev_line[s]) begin
                    hi_run[s]++;
                end else if (!lines[s] && prev_line[s] && pulse_valid[s]) begin
                    if (hi_run[s] != ws2812_pkg::T0H_CYCLES
                            && hi_run[s] != ws2812_pkg::T1H_CYCLES) begin
                        note_failure($sformatf("%s high pulse of %0d cycles is neither 17 nor 51",
                                               strip_name(s), hi_run[s]));
                    end
                    cur_word[s] = {cur_word[s][22:0], hi_run[s] == ws2812_pkg::T1H_CYCLES};
                    bit_cnt[s]++;
                    if (bit_cnt[s] == ws2812_pkg::BITS_PER_PIXEL) begin
                        bit_cnt[s] = 0;
                        if (word_cnt[s] < 20) begin
                            dec_words[s][word_cnt[s]] = cur_word[s];
                            word_cnt[s]++;
                        end else begin
                            note_failure($sformatf("%s sent more than 20 pixels", strip_name(s)));
                        end
                    end
                end
            end
            prev_line[s] = lines[s];
        end
    end

    // compare each finished frame against the reference
    always @(negedge sys_clk) begin
        if (sys_rst_n && frame_done) begin
            done_count++;
            check_val("busy", 32'(busy), 32'd0);
            for (int s = 0; s < 2; s++) begin
                check_val($sformatf("%s word count", strip_name(s)), 32'(word_cnt[s]), 32'd20);
                check_val($sformatf("%s trailing bits", strip_name(s)), 32'(bit_cnt[s]), 32'd0);
                for (int p = 0; p < 20; p++) begin
                    check_val($sformatf("%s word[%0d]", strip_name(s), p),
                              32'(dec_words[s][p]), 32'(expected_word(sent_frame, s, p)));
                end
            end
        end
    end

    task automatic start_frame(input logic [ws2812_pkg::FRAME_BITS-1:0] f);
        @(negedge sys_clk);
        frame_data  = f;
        frame_start = 1'b1;
        sent_frame  = f;
        @(negedge sys_clk);
        frame_start = 1'b0;
    endtask

    task automatic watch_idle(input int cycles);
        repeat (cycles) begin
            @(negedge sys_clk);
            check_val("strip_a", 32'(strip_a), 32'd0);
            check_val("strip_b", 32'(strip_b), 32'd0);
            check_val("busy", 32'(busy), 32'd0);
            check_val("frame_done", 32'(frame_done), 32'd0);
        end
    endtask

    task automatic wait_done();
        int done_before;
        done_before = done_count;
        while (done_count == done_before) begin
            @(negedge sys_clk);
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        $display("test %s: %s", name, (error_count == err_before) ? "ok" : "failed");
    endtask

    initial begin
        int err_before;
        int done_before;
        void'($urandom(32'h0697_d871));
        sys_rst_n   = 1'b0;
        frame_start = 1'b0;
        frame_data  = '0;
        repeat (2) @(negedge sys_clk);
        sys_rst_n = 1'b1;

        err_before = error_count;
        watch_idle(100);
        end_test("idle after reset", err_before);

        err_before = error_count;
        start_frame(random_frame());
        check_val("busy", 32'(busy), 32'd1);  // high one cycle after the start edge
        wait_done();
        end_test("first frame", err_before);

        err_before = error_count;
        watch_idle(500);
        start_frame(random_frame());
        wait_done();
        watch_idle(500);
        end_test("frame end and second frame", err_before);

        err_before = error_count;
        start_frame(random_frame());
        while (word_cnt[0] < 8) begin
            @(negedge sys_clk);
        end
        done_before = done_count;
        start_frame(random_frame());
        @(negedge sys_clk);
        check_val("strip_a", 32'(strip_a), 32'd0);
        check_val("strip_b", 32'(strip_b), 32'd0);
        wait_done();
        check_val("frame_done count", 32'(done_count - done_before), 32'd1);
        watch_idle(200);
        end_test("restart mid frame", err_before);

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- files.f
ws2812_pkg.sv
ws2812_pixel_buffer.sv
ws2812_sequencer.sv
ws2812_bit_encoder.sv
ws2812_top.sv
tb_ws2812.sv

//--- Makefile
# Verilator build and run for the WS2812 two-strip driver

VERILATOR ?= verilator
TOP       ?= tb_ws2812
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_MSG  ?= All tests passed!

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BINARY) | tee $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
